/* hdl/bsx_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared constants and types of the bit-serial
// execution subsystem, referenced by scoped names
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package bsx_pkg;

   localparam int XLEN = 32;

   // apb register map in byte addresses
   localparam logic [7:0] ADDR_CTRL   = 8'h00;
   localparam logic [7:0] ADDR_STATUS = 8'h04;
   localparam logic [7:0] ADDR_RS1    = 8'h08;
   localparam logic [7:0] ADDR_RS2    = 8'h0C;
   localparam logic [7:0] ADDR_INSTR  = 8'h10;
   localparam logic [7:0] ADDR_RESULT = 8'h14;

   // status word bit positions
   localparam int STS_BUSY    = 0;
   localparam int STS_DONE    = 1;
   localparam int STS_ILLEGAL = 2;
   localparam int STS_TAKEN   = 3;

   // rv32i opcodes in scope
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;

   // funct3 for alu and compare ops
   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;
   // funct3 for branches
   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;
   // funct7 alt selects sub
   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;

   typedef struct packed {
      logic [7:0]  paddr;
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [31:0] pwdata;
   } bsx_apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } bsx_apb_rsp_t;

   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_XOR = 2'd1,
      ALU_OR  = 2'd2,
      ALU_AND = 2'd3
   } bsx_alu_op_e;

   typedef struct packed {
      bsx_alu_op_e alu_op;
      logic        sub;
      logic        use_imm;
      logic        cmp_op;
      logic        is_unsigned;
      logic        branch;
      logic        cond_invert;
      logic        cond_eq;
      logic        illegal;
   } bsx_ctrl_t;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } bsx_r_view_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } bsx_i_view_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } bsx_b_view_t;

   // one instruction word in three encodings
   typedef union packed {
      bsx_r_view_t r_view;
      bsx_i_view_t i_view;
      bsx_b_view_t b_view;
   } bsx_instr_u;

   typedef struct packed {
      logic busy;
      logic done;
      logic illegal;
      logic taken;
   } bsx_status_t;

endpackage

`default_nettype wire

/* hdl/bsx_apb_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// apb slave with the operand, instruction, ctrl
// and status registers; no wait states, a start
// write pulses o_start for one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module bsx_apb_regs (
   input  wire                      i_clk,
   input  wire                      i_rst,
   input  bsx_pkg::bsx_apb_req_t    i_apb,
   output bsx_pkg::bsx_apb_rsp_t    o_apb,
   input  wire                      i_busy,
   input  wire                      i_done,
   input  wire                      i_illegal,
   input  wire                      i_taken,
   input  wire [bsx_pkg::XLEN-1:0]  i_result,
   output logic                     o_start,
   output bsx_pkg::bsx_instr_u      o_instr,
   output logic [bsx_pkg::XLEN-1:0] o_rs1,
   output logic [bsx_pkg::XLEN-1:0] o_rs2
);

   logic                     access;
   logic                     known;
   logic                     read_only;
   logic                     err;
   logic                     wr_ok;
   logic                     start_req;
   logic                     done_q;
   logic                     illegal_q;
   logic                     taken_q;
   logic [bsx_pkg::XLEN-1:0] result_q;
   logic [bsx_pkg::XLEN-1:0] rdata;
   bsx_pkg::bsx_status_t     sts;

   // access phase always completes
   assign access = i_apb.psel & i_apb.penable;

   assign known = (i_apb.paddr == bsx_pkg::ADDR_CTRL)  | (i_apb.paddr == bsx_pkg::ADDR_STATUS) |
                  (i_apb.paddr == bsx_pkg::ADDR_RS1)   | (i_apb.paddr == bsx_pkg::ADDR_RS2)    |
                  (i_apb.paddr == bsx_pkg::ADDR_INSTR) | (i_apb.paddr == bsx_pkg::ADDR_RESULT);
   assign read_only = (i_apb.paddr == bsx_pkg::ADDR_STATUS) |
                      (i_apb.paddr == bsx_pkg::ADDR_RESULT);

   // bad address, ro write or any write while busy
   assign err       = access & (~known | (i_apb.pwrite & (read_only | i_busy)));
   assign wr_ok     = access & i_apb.pwrite & ~err;
   assign start_req = wr_ok & (i_apb.paddr == bsx_pkg::ADDR_CTRL) & i_apb.pwdata[0];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_start   <= 1'b0;
         o_rs1     <= '0;
         o_rs2     <= '0;
         o_instr   <= '0;
         done_q    <= 1'b0;
         illegal_q <= 1'b0;
         taken_q   <= 1'b0;
         result_q  <= '0;
      end else begin
         o_start <= start_req;
         if (wr_ok & (i_apb.paddr == bsx_pkg::ADDR_RS1))
            o_rs1 <= i_apb.pwdata;
         if (wr_ok & (i_apb.paddr == bsx_pkg::ADDR_RS2))
            o_rs2 <= i_apb.pwdata;
         if (wr_ok & (i_apb.paddr == bsx_pkg::ADDR_INSTR))
            o_instr <= i_apb.pwdata;
         // capture outcome of the finished op
         if (i_done) begin
            done_q    <= 1'b1;
            illegal_q <= i_illegal;
            taken_q   <= i_taken;
            result_q  <= i_result;
         end else if (start_req) begin
            done_q <= 1'b0;
         end
      end
   end

   // busy is live, the rest held since done
   assign sts.busy    = i_busy;
   assign sts.done    = done_q;
   assign sts.illegal = illegal_q;
   assign sts.taken   = taken_q;

   always_comb begin
      rdata = '0;
      case (i_apb.paddr)
         bsx_pkg::ADDR_STATUS: begin
            rdata[bsx_pkg::STS_BUSY]    = sts.busy;
            rdata[bsx_pkg::STS_DONE]    = sts.done;
            rdata[bsx_pkg::STS_ILLEGAL] = sts.illegal;
            rdata[bsx_pkg::STS_TAKEN]   = sts.taken;
         end
         bsx_pkg::ADDR_RS1:    rdata = o_rs1;
         bsx_pkg::ADDR_RS2:    rdata = o_rs2;
         bsx_pkg::ADDR_INSTR:  rdata = o_instr;
         bsx_pkg::ADDR_RESULT: rdata = result_q;
         default:              rdata = '0;
      endcase
   end

   assign o_apb.prdata  = (access & ~i_apb.pwrite) ? rdata : '0;
   assign o_apb.pready  = 1'b1;
   assign o_apb.pslverr = err;

endmodule

`default_nettype wire

/* hdl/bsx_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational rv32i decoder for the alu, compare
// and branch subset; anything else is illegal
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module bsx_decode (
   input  bsx_pkg::bsx_instr_u      i_instr,
   output bsx_pkg::bsx_ctrl_t       o_ctrl,
   output logic [bsx_pkg::XLEN-1:0] o_imm
);

   logic       is_op;
   logic       is_imm;
   logic [2:0] f3;
   logic       f7_alt;
   logic       f7_ok;

   assign is_op  = (i_instr.r_view.opcode == bsx_pkg::OPC_OP);
   assign is_imm = (i_instr.r_view.opcode == bsx_pkg::OPC_OP_IMM);

   // funct3 sits in the same bits in r and i words
   assign f3 = i_instr.r_view.funct3;

   // funct7 only matters for r-type, alt only with add
   assign f7_alt = (i_instr.r_view.funct7 == bsx_pkg::F7_ALT);
   assign f7_ok  = is_imm | (i_instr.r_view.funct7 == bsx_pkg::F7_BASE) |
                   (f7_alt & (f3 == bsx_pkg::F3_ADD));

   // i-type immediate, sign extended
   assign o_imm = {{(bsx_pkg::XLEN-12){i_instr.i_view.imm[11]}}, i_instr.i_view.imm};

   always_comb begin
      o_ctrl = '0;
      if (is_op | is_imm) begin
         o_ctrl.use_imm = is_imm;
         o_ctrl.illegal = ~f7_ok;
         case (f3)
            bsx_pkg::F3_ADD: o_ctrl.sub = is_op & f7_alt;
            bsx_pkg::F3_XOR: o_ctrl.alu_op = bsx_pkg::ALU_XOR;
            bsx_pkg::F3_OR:  o_ctrl.alu_op = bsx_pkg::ALU_OR;
            bsx_pkg::F3_AND: o_ctrl.alu_op = bsx_pkg::ALU_AND;
            bsx_pkg::F3_SLT: begin
               o_ctrl.sub    = 1'b1;
               o_ctrl.cmp_op = 1'b1;
            end
            bsx_pkg::F3_SLTU: begin
               o_ctrl.sub         = 1'b1;
               o_ctrl.cmp_op      = 1'b1;
               o_ctrl.is_unsigned = 1'b1;
            end
            // shifts are out of scope
            default: o_ctrl.illegal = 1'b1;
         endcase
      end else if (i_instr.b_view.opcode == bsx_pkg::OPC_BRANCH) begin
         // branches compare by subtracting rs2
         o_ctrl.sub    = 1'b1;
         o_ctrl.branch = 1'b1;
         case (i_instr.b_view.funct3)
            bsx_pkg::F3_BEQ:  o_ctrl.cond_eq = 1'b1;
            bsx_pkg::F3_BNE: begin
               o_ctrl.cond_eq     = 1'b1;
               o_ctrl.cond_invert = 1'b1;
            end
            bsx_pkg::F3_BLT:  o_ctrl.cond_eq = 1'b0;
            bsx_pkg::F3_BGE:  o_ctrl.cond_invert = 1'b1;
            bsx_pkg::F3_BLTU: o_ctrl.is_unsigned = 1'b1;
            bsx_pkg::F3_BGEU: begin
               o_ctrl.is_unsigned = 1'b1;
               o_ctrl.cond_invert = 1'b1;
            end
            default: o_ctrl.illegal = 1'b1;
         endcase
      end else begin
         o_ctrl.illegal = 1'b1;
      end
   end

endmodule

`default_nettype wire

/* hdl/bsx_state.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sequencer for one serial op: init cycle, 32
// counted bit cycles and a done pulse on the last
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module bsx_state (
   input  wire  i_clk,
   input  wire  i_rst,
   input  wire  i_start,
   input  wire  i_illegal,
   output logic o_init,
   output logic o_cnt_en,
   output logic o_cnt0,
   output logic o_last,
   output logic o_done,
   output logic o_busy
);

   logic       init_q;
   logic       ill_q;
   logic [2:0] cnt_hi;
   logic [3:0] ring;

   // count = {cnt_hi, one-hot position in ring}
   // ring advances every cycle, cnt_hi once per lap
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         init_q <= 1'b0;
         ill_q  <= 1'b0;
         cnt_hi <= 3'd0;
         ring   <= 4'b0000;
      end else begin
         // an illegal op never enters init
         init_q <= i_start & ~i_illegal;
         ill_q  <= i_start & i_illegal;
         cnt_hi <= cnt_hi + {2'd0, ring[3]};
         // init seeds the ring, last bit lets it drain
         ring   <= {ring[2:0], (ring[3] & ~o_last) | init_q};
      end
   end

   assign o_init   = init_q;
   assign o_cnt_en = |ring;
   assign o_cnt0   = (cnt_hi == 3'd0) & ring[0];
   assign o_last   = (cnt_hi == 3'd7) & ring[3];

   // done on bit 31, or right away for an illegal start
   assign o_done = o_last | ill_q;
   assign o_busy = init_q | o_cnt_en | ill_q;

endmodule

`default_nettype wire

/* hdl/bsx_execute.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// serial execute stage: operand shift registers
// and a one-bit adder/logic unit, lsb first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module bsx_execute (
   input  wire                     i_clk,
   input  wire                     i_rst,
   input  wire                     i_init,
   input  wire                     i_cnt_en,
   input  wire                     i_cnt0,
   input  bsx_pkg::bsx_ctrl_t      i_ctrl,
   input  wire [bsx_pkg::XLEN-1:0] i_rs1,
   input  wire [bsx_pkg::XLEN-1:0] i_rs2,
   input  wire [bsx_pkg::XLEN-1:0] i_imm,
   output logic                    o_rd_bit,
   output logic                    o_sum_bit,
   output logic                    o_a_bit,
   output logic                    o_b_bit
);

   logic [bsx_pkg::XLEN-1:0] a_q;
   logic [bsx_pkg::XLEN-1:0] b_q;
   logic                     carry_q;
   logic                     carry_in;
   logic                     b_eff;
   logic                     carry_out;

   // operands load on init, then shift right each bit
   always_ff @(posedge i_clk) begin
      if (i_init) begin
         a_q <= i_rs1;
         b_q <= i_ctrl.use_imm ? i_imm : i_rs2;
      end else if (i_cnt_en) begin
         a_q <= {1'b0, a_q[bsx_pkg::XLEN-1:1]};
         b_q <= {1'b0, b_q[bsx_pkg::XLEN-1:1]};
      end
   end

   // carry preset to sub gives the +1 of two's complement
   always_ff @(posedge i_clk) begin
      if (i_rst)
         carry_q <= 1'b0;
      else if (i_init)
         carry_q <= i_ctrl.sub;
      else if (i_cnt_en)
         carry_q <= carry_out;
   end

   assign o_a_bit = a_q[0];
   assign o_b_bit = b_q[0];

   // bit 0 takes its carry straight from sub
   assign carry_in = i_cnt0 ? i_ctrl.sub : carry_q;

   // b inverted for subtract
   assign b_eff     = o_b_bit ^ i_ctrl.sub;
   assign o_sum_bit = o_a_bit ^ b_eff ^ carry_in;
   assign carry_out = (o_a_bit & b_eff) | (carry_in & (o_a_bit ^ b_eff));

   always_comb begin
      case (i_ctrl.alu_op)
         bsx_pkg::ALU_ADD: o_rd_bit = o_sum_bit;
         bsx_pkg::ALU_XOR: o_rd_bit = o_a_bit ^ o_b_bit;
         bsx_pkg::ALU_OR:  o_rd_bit = o_a_bit | o_b_bit;
         bsx_pkg::ALU_AND: o_rd_bit = o_a_bit & o_b_bit;
         default:          o_rd_bit = o_sum_bit;
      endcase
   end

endmodule

`default_nettype wire

/* hdl/bsx_result.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// collects the serial result word and forms the
// less-than, equality and branch taken flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module bsx_result (
   input  wire                      i_clk,
   input  wire                      i_rst,
   input  wire                      i_init,
   input  wire                      i_cnt_en,
   input  wire                      i_last,
   input  wire                      i_done,
   input  bsx_pkg::bsx_ctrl_t       i_ctrl,
   input  wire                      i_rd_bit,
   input  wire                      i_sum_bit,
   input  wire                      i_a_bit,
   input  wire                      i_b_bit,
   output logic [bsx_pkg::XLEN-1:0] o_result,
   output logic                     o_taken,
   output logic                     o_illegal
);

   logic [bsx_pkg::XLEN-1:0] res_q;
   logic [bsx_pkg::XLEN-1:0] res_next;
   logic                     eq_q;
   logic                     eq_all;
   logic                     lt;
   logic                     cmp_flag;

   // bits enter at the msb end and walk down
   assign res_next = {i_rd_bit, res_q[bsx_pkg::XLEN-1:1]};

   always_ff @(posedge i_clk) begin
      if (i_cnt_en)
         res_q <= res_next;
   end

   // stays set while every difference bit is zero
   always_ff @(posedge i_clk) begin
      if (i_rst)
         eq_q <= 1'b0;
      else if (i_init)
         eq_q <= 1'b1;
      else if (i_cnt_en)
         eq_q <= eq_all;
   end

   assign eq_all = eq_q & ~i_sum_bit;

   // on the sign bit: differing signs decide directly,
   // otherwise the sign of a - b
   assign lt = (i_a_bit ^ i_b_bit) ? (i_ctrl.is_unsigned ? i_b_bit : i_a_bit) : i_sum_bit;

   assign cmp_flag = i_ctrl.cond_eq ? eq_all : lt;
   assign o_taken  = i_last & i_ctrl.branch & (cmp_flag ^ i_ctrl.cond_invert);
   assign o_illegal = i_done & i_ctrl.illegal;

   // final word as it stands after the last shift
   always_comb begin
      if (i_ctrl.illegal)
         o_result = '0;
      else if (i_ctrl.cmp_op)
         o_result = {{(bsx_pkg::XLEN-1){1'b0}}, lt};
      else
         o_result = res_next;
   end

endmodule

`default_nettype wire

/* hdl/bsx_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top of the bit-serial execution subsystem,
// one apb slave port toward the host
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module bsx_top (
   input  wire                   i_clk,
   input  wire                   i_rst,
   input  bsx_pkg::bsx_apb_req_t i_apb,
   output bsx_pkg::bsx_apb_rsp_t o_apb
);

   logic                     start;
   bsx_pkg::bsx_instr_u      instr;
   logic [bsx_pkg::XLEN-1:0] rs1;
   logic [bsx_pkg::XLEN-1:0] rs2;
   bsx_pkg::bsx_ctrl_t       ctrl;
   logic [bsx_pkg::XLEN-1:0] imm;
   logic                     init;
   logic                     cnt_en;
   logic                     cnt0;
   logic                     last;
   logic                     done;
   logic                     busy;
   logic                     rd_bit;
   logic                     sum_bit;
   logic                     a_bit;
   logic                     b_bit;
   logic [bsx_pkg::XLEN-1:0] result;
   logic                     taken;
   logic                     illegal;

   bsx_apb_regs regs_i (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_apb     (i_apb),
      .o_apb     (o_apb),
      .i_busy    (busy),
      .i_done    (done),
      .i_illegal (illegal),
      .i_taken   (taken),
      .i_result  (result),
      .o_start   (start),
      .o_instr   (instr),
      .o_rs1     (rs1),
      .o_rs2     (rs2)
   );

   bsx_decode decode_i (
      .i_instr (instr),
      .o_ctrl  (ctrl),
      .o_imm   (imm)
   );

   // illegal starts skip straight to done
   bsx_state state_i (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_start   (start),
      .i_illegal (ctrl.illegal),
      .o_init    (init),
      .o_cnt_en  (cnt_en),
      .o_cnt0    (cnt0),
      .o_last    (last),
      .o_done    (done),
      .o_busy    (busy)
   );

   bsx_execute execute_i (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_init    (init),
      .i_cnt_en  (cnt_en),
      .i_cnt0    (cnt0),
      .i_ctrl    (ctrl),
      .i_rs1     (rs1),
      .i_rs2     (rs2),
      .i_imm     (imm),
      .o_rd_bit  (rd_bit),
      .o_sum_bit (sum_bit),
      .o_a_bit   (a_bit),
      .o_b_bit   (b_bit)
   );

   bsx_result result_i (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_init    (init),
      .i_cnt_en  (cnt_en),
      .i_last    (last),
      .i_done    (done),
      .i_ctrl    (ctrl),
      .i_rd_bit  (rd_bit),
      .i_sum_bit (sum_bit),
      .i_a_bit   (a_bit),
      .i_b_bit   (b_bit),
      .o_result  (result),
      .o_taken   (taken),
      .o_illegal (illegal)
   );

endmodule

`default_nettype wire

/* tb/tb_bsx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the bit-serial execution
// subsystem; drives the apb port of the top level,
// predicts results from rv32i semantics and
// checks result, status and slave error flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_bsx;

   localparam int N_RAND       = 20;
   localparam int MAX_POLLS    = 40;
   // apb rules, r-type, i-type, compares, branches, illegal
   localparam int N_OPS        = 6 + 5 * (9 + N_RAND) + 24 + 12 + 24 + 3;
   localparam int TIMEOUT_CYC  = N_OPS * 70 + 500;

   logic                  clk = 1'b0;
   logic                  rst;
   bsx_pkg::bsx_apb_req_t apb_req;
   bsx_pkg::bsx_apb_rsp_t apb_rsp;
   logic [31:0]           lcg_state = 32'd18;
   int                    n_checks = 0;
   int                    n_errors = 0;
   int                    cycles = 0;

   bsx_top dut_i (
      .i_clk (clk),
      .i_rst (rst),
      .i_apb (apb_req),
      .o_apb (apb_rsp)
   );

   always #5 clk = ~clk;

   // hard stop if a test never returns
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYC) begin
         $display("timeout: run still going after %0d cycles", TIMEOUT_CYC);
         $display("TESTS FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = 32'd1664525 * lcg_state + 32'd1013904223;
      return lcg_state;
   endfunction

   // instruction words with rd=x3 rs1=x1 rs2=x2
   function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3);
      return {f7, 5'd2, 5'd1, f3, 5'd3, bsx_pkg::OPC_OP};
   endfunction

   function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3);
      return {imm, 5'd1, f3, 5'd3, bsx_pkg::OPC_OP_IMM};
   endfunction

   function automatic logic [31:0] b_word(input logic [2:0] f3);
      return {7'd0, 5'd2, 5'd1, f3, 5'd0, bsx_pkg::OPC_BRANCH};
   endfunction

   function automatic bsx_pkg::bsx_status_t to_status(input logic [31:0] w);
      bsx_pkg::bsx_status_t s;
      s.busy    = w[bsx_pkg::STS_BUSY];
      s.done    = w[bsx_pkg::STS_DONE];
      s.illegal = w[bsx_pkg::STS_ILLEGAL];
      s.taken   = w[bsx_pkg::STS_TAKEN];
      return s;
   endfunction

   // reference model from the rv32i field layout and semantics
   task automatic predict(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b,
                          output logic [31:0] res, output bsx_pkg::bsx_status_t sts);
      logic [6:0]  opc;
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [31:0] op_b;
      logic        bad;
      opc  = ins[6:0];
      f3   = ins[14:12];
      f7   = ins[31:25];
      op_b = (opc == bsx_pkg::OPC_OP_IMM) ? {{20{ins[31]}}, ins[31:20]} : b;
      res  = '0;
      sts  = '0;
      sts.done = 1'b1;
      bad  = 1'b0;
      if (opc == bsx_pkg::OPC_OP || opc == bsx_pkg::OPC_OP_IMM) begin
         // r-type: funct7 zero, or 0x20 for sub only
         if (opc == bsx_pkg::OPC_OP)
            bad = !(f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b000));
         case (f3)
            3'b000:  res = (opc == bsx_pkg::OPC_OP && f7[5]) ? a - op_b : a + op_b;
            3'b010:  res = {31'd0, ($signed(a) < $signed(op_b))};
            3'b011:  res = {31'd0, (a < op_b)};
            3'b100:  res = a ^ op_b;
            3'b110:  res = a | op_b;
            3'b111:  res = a & op_b;
            default: bad = 1'b1;
         endcase
      end else if (opc == bsx_pkg::OPC_BRANCH) begin
         case (f3)
            3'b000:  sts.taken = (a == b);
            3'b001:  sts.taken = (a != b);
            3'b100:  sts.taken = ($signed(a) < $signed(b));
            3'b101:  sts.taken = ($signed(a) >= $signed(b));
            3'b110:  sts.taken = (a < b);
            3'b111:  sts.taken = (a >= b);
            default: bad = 1'b1;
         endcase
      end else begin
         bad = 1'b1;
      end
      if (bad) begin
         res       = '0;
         sts.taken = 1'b0;
      end
      sts.illegal = bad;
   endtask

   task automatic check_word(input string what, input logic [bsx_pkg::XLEN-1:0] got,
                             input logic [bsx_pkg::XLEN-1:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_status(input string what, input bsx_pkg::bsx_status_t got,
                               input bsx_pkg::bsx_status_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("ERR %0t: %s got %b expected %b (busy done illegal taken)",
                  $time, what, got, exp);
      end
   endtask

   task automatic check_err(input string what, input bsx_pkg::bsx_apb_rsp_t got,
                            input logic exp_err);
      n_checks++;
      if (got.pslverr !== exp_err || got.pready !== 1'b1) begin
         n_errors++;
         $display("ERR %0t: %s pslverr %b pready %b expected pslverr %b",
                  $time, what, got.pslverr, got.pready, exp_err);
      end
   endtask

   // setup on one falling edge, access on the next, idle after the write edge
   task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                           output bsx_pkg::bsx_apb_rsp_t rsp);
      @(negedge clk);
      apb_req.paddr   = addr;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = wr;
      apb_req.pwdata  = wr ? data : '0;
      @(negedge clk);
      apb_req.penable = 1'b1;
      // mid low phase where the response has settled
      #2;
      rsp = apb_rsp;
      @(negedge clk);
      apb_req = '0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                            output bsx_pkg::bsx_apb_rsp_t rsp);
      apb_xfer(1'b1, addr, data, rsp);
   endtask

   task automatic apb_read(input logic [7:0] addr, output bsx_pkg::bsx_apb_rsp_t rsp);
      apb_xfer(1'b0, addr, 32'd0, rsp);
   endtask

   task automatic load_op(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b);
      bsx_pkg::bsx_apb_rsp_t rsp;
      apb_write(bsx_pkg::ADDR_RS1, a, rsp);
      check_err("rs1 write", rsp, 1'b0);
      apb_write(bsx_pkg::ADDR_RS2, b, rsp);
      check_err("rs2 write", rsp, 1'b0);
      apb_write(bsx_pkg::ADDR_INSTR, ins, rsp);
      check_err("instr write", rsp, 1'b0);
   endtask

   task automatic start_op();
      bsx_pkg::bsx_apb_rsp_t rsp;
      apb_write(bsx_pkg::ADDR_CTRL, 32'd1, rsp);
      check_err("start write", rsp, 1'b0);
   endtask

   // poll status until done within a bound
   task automatic wait_done(output bsx_pkg::bsx_status_t sts);
      bsx_pkg::bsx_apb_rsp_t rsp;
      int polls;
      polls = 0;
      sts   = '0;
      while (!sts.done && polls < MAX_POLLS) begin
         apb_read(bsx_pkg::ADDR_STATUS, rsp);
         sts = to_status(rsp.prdata);
         polls++;
      end
      if (!sts.done) begin
         n_errors++;
         $display("done bit never set after %0d status polls at %0t", MAX_POLLS, $time);
      end
   endtask

   task automatic run_op(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b,
                         input logic check_res);
      bsx_pkg::bsx_apb_rsp_t rsp;
      bsx_pkg::bsx_status_t  sts;
      bsx_pkg::bsx_status_t  exp_sts;
      logic [31:0]           exp_res;
      predict(ins, a, b, exp_res, exp_sts);
      load_op(ins, a, b);
      start_op();
      wait_done(sts);
      check_status("status", sts, exp_sts);
      if (check_res) begin
         apb_read(bsx_pkg::ADDR_RESULT, rsp);
         check_word("result", rsp.prdata, exp_res);
      end
   endtask

   task automatic apb_rule_tests();
      bsx_pkg::bsx_apb_rsp_t rsp;
      bsx_pkg::bsx_status_t  sts;
      bsx_pkg::bsx_status_t  exp_sts;
      logic [31:0]           v;
      logic [31:0]           exp_res;
      apb_read(bsx_pkg::ADDR_STATUS, rsp);
      check_status("status after reset", to_status(rsp.prdata), '0);
      v = lcg_next();
      apb_write(bsx_pkg::ADDR_RS1, v, rsp);
      apb_read(bsx_pkg::ADDR_RS1, rsp);
      check_word("rs1 readback", rsp.prdata, v);
      v = lcg_next();
      apb_write(bsx_pkg::ADDR_RS2, v, rsp);
      apb_read(bsx_pkg::ADDR_RS2, rsp);
      check_word("rs2 readback", rsp.prdata, v);
      v = lcg_next();
      apb_write(bsx_pkg::ADDR_INSTR, v, rsp);
      apb_read(bsx_pkg::ADDR_INSTR, rsp);
      check_word("instr readback", rsp.prdata, v);
      // a clean add leaves illegal and taken low
      run_op(r_word(bsx_pkg::F7_BASE, bsx_pkg::F3_ADD), 32'h11, 32'h22, 1'b1);
      // second start clears done and shows busy at once
      load_op(r_word(bsx_pkg::F7_ALT, bsx_pkg::F3_ADD), 32'h1000, 32'h1);
      predict(r_word(bsx_pkg::F7_ALT, bsx_pkg::F3_ADD), 32'h1000, 32'h1, exp_res, exp_sts);
      start_op();
      apb_read(bsx_pkg::ADDR_STATUS, rsp);
      sts      = '0;
      sts.busy = 1'b1;
      check_status("status right after start", to_status(rsp.prdata), sts);
      apb_write(bsx_pkg::ADDR_RS1, 32'hdead_beef, rsp);
      check_err("rs1 write while busy", rsp, 1'b1);
      apb_write(bsx_pkg::ADDR_CTRL, 32'd1, rsp);
      check_err("start while busy", rsp, 1'b1);
      wait_done(sts);
      check_status("status after busy writes", sts, exp_sts);
      apb_read(bsx_pkg::ADDR_RESULT, rsp);
      check_word("result after busy writes", rsp.prdata, exp_res);
      apb_read(bsx_pkg::ADDR_RS1, rsp);
      check_word("rs1 kept while busy", rsp.prdata, 32'h1000);
      apb_write(bsx_pkg::ADDR_RESULT, 32'd5, rsp);
      check_err("result write", rsp, 1'b1);
      apb_write(8'h18, 32'd5, rsp);
      check_err("unknown address write", rsp, 1'b1);
   endtask

   task automatic r_type_tests();
      logic [31:0] ops [5];
      logic [31:0] edge_v [3];
      ops[0] = r_word(bsx_pkg::F7_BASE, bsx_pkg::F3_ADD);
      ops[1] = r_word(bsx_pkg::F7_ALT, bsx_pkg::F3_ADD);
      ops[2] = r_word(bsx_pkg::F7_BASE, bsx_pkg::F3_XOR);
      ops[3] = r_word(bsx_pkg::F7_BASE, bsx_pkg::F3_OR);
      ops[4] = r_word(bsx_pkg::F7_BASE, bsx_pkg::F3_AND);
      edge_v[0] = 32'h0000_0000;
      edge_v[1] = 32'hffff_ffff;
      edge_v[2] = 32'h8000_0000;
      for (int k = 0; k < 5; k++) begin
         for (int i = 0; i < 3; i++)
            for (int j = 0; j < 3; j++)
               run_op(ops[k], edge_v[i], edge_v[j], 1'b1);
         for (int n = 0; n < N_RAND; n++)
            run_op(ops[k], lcg_next(), lcg_next(), 1'b1);
      end
   endtask

   task automatic i_type_tests();
      logic [2:0]  f3s [6];
      logic [11:0] imms [4];
      f3s[0]  = bsx_pkg::F3_ADD;
      f3s[1]  = bsx_pkg::F3_XOR;
      f3s[2]  = bsx_pkg::F3_OR;
      f3s[3]  = bsx_pkg::F3_AND;
      f3s[4]  = bsx_pkg::F3_SLT;
      f3s[5]  = bsx_pkg::F3_SLTU;
      // -1, -2048, 2047 and a small positive one
      imms[0] = 12'hfff;
      imms[1] = 12'h800;
      imms[2] = 12'h7ff;
      imms[3] = 12'h035;
      // rs2 random so a missed immediate select shows
      for (int k = 0; k < 6; k++)
         for (int i = 0; i < 4; i++)
            run_op(i_word(imms[i], f3s[k]), lcg_next(), lcg_next(), 1'b1);
   endtask

   task automatic compare_tests();
      logic [31:0] ca [6];
      logic [31:0] cb [6];
      ca[0] = 32'd5;
      cb[0] = 32'd9;
      ca[1] = 32'd9;
      cb[1] = 32'd5;
      ca[2] = 32'd7;
      cb[2] = 32'd7;
      ca[3] = 32'hffff_fff0;
      cb[3] = 32'hffff_fff8;
      ca[4] = 32'h8000_0000;
      cb[4] = 32'd1;
      ca[5] = 32'd1;
      cb[5] = 32'hffff_ffff;
      for (int i = 0; i < 6; i++) begin
         run_op(r_word(bsx_pkg::F7_BASE, bsx_pkg::F3_SLT), ca[i], cb[i], 1'b1);
         run_op(r_word(bsx_pkg::F7_BASE, bsx_pkg::F3_SLTU), ca[i], cb[i], 1'b1);
      end
   endtask

   task automatic branch_tests();
      logic [31:0] ba [4];
      logic [31:0] bb [4];
      // equal, less signed only, greater and less unsigned only
      ba[0] = 32'h1234_5678;
      bb[0] = 32'h1234_5678;
      ba[1] = 32'hffff_fffe;
      bb[1] = 32'd3;
      ba[2] = 32'd7;
      bb[2] = 32'd3;
      ba[3] = 32'd3;
      bb[3] = 32'hffff_fffe;
      for (int i = 0; i < 4; i++) begin
         run_op(b_word(bsx_pkg::F3_BEQ), ba[i], bb[i], 1'b0);
         run_op(b_word(bsx_pkg::F3_BNE), ba[i], bb[i], 1'b0);
         run_op(b_word(bsx_pkg::F3_BLT), ba[i], bb[i], 1'b0);
         run_op(b_word(bsx_pkg::F3_BGE), ba[i], bb[i], 1'b0);
         run_op(b_word(bsx_pkg::F3_BLTU), ba[i], bb[i], 1'b0);
         run_op(b_word(bsx_pkg::F3_BGEU), ba[i], bb[i], 1'b0);
      end
      // load opcode, mul funct7, xor with the sub funct7
      run_op({12'd0, 5'd1, 3'b010, 5'd3, 7'b0000011}, 32'd4, 32'd4, 1'b1);
      run_op(r_word(7'b0000001, bsx_pkg::F3_ADD), 32'd6, 32'd7, 1'b1);
      run_op(r_word(bsx_pkg::F7_ALT, bsx_pkg::F3_XOR), 32'd6, 32'd7, 1'b1);
   endtask

   initial begin
      rst     = 1'b1;
      apb_req = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      apb_rule_tests();
      r_type_tests();
      i_type_tests();
      compare_tests();
      branch_tests();
      $display("checks %0d errors %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
hdl/bsx_pkg.sv
hdl/bsx_apb_regs.sv
hdl/bsx_decode.sv
hdl/bsx_state.sv
hdl/bsx_execute.sv
hdl/bsx_result.sv
hdl/bsx_top.sv
tb/tb_bsx.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_bsx
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
